// ==== source/fir_defines.svh ====
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// filter geometry
`define FIR_TAPS 8
`define FIR_DATA_WIDTH 14
`define FIR_COEF_WIDTH 18
// fraction bits in each coefficient
`define FIR_COEF_MAG 17
// product width plus growth for the tap sum
`define FIR_ACC_WIDTH (`FIR_DATA_WIDTH + `FIR_COEF_WIDTH + $clog2(`FIR_TAPS))

// bus widths
`define AXI_DATA_WIDTH 32
`define AXI_ADDR_WIDTH 9
// byte to word address shift
`define AXI_ADDR_LSB 2

// register word addresses
`define REG_NAME 0
`define REG_VER 1
`define REG_TAPS 4
`define REG_COEF_MAG 12
`define REG_COEF_BASE 16
`define REG_SWITCHES 20

// first coefficient word
`define COEF_BASE 64
// switches bit that turns the filter on
`define SWITCH_FIR_EN 1

// id words, read back byte reversed
`define PROG_NAME " RIF"
`define PROG_VER "12.3"

`endif

// ==== source/fir_pkg.sv ====
package fir_pkg;

	`include "fir_defines.svh"

	// datapath words
	typedef logic [`FIR_DATA_WIDTH-1:0] sample_t;
	typedef logic [`FIR_COEF_WIDTH-1:0] coef_t;
	typedef logic [`FIR_ACC_WIDTH-1:0] acc_t;
	typedef logic [$clog2(`FIR_TAPS)-1:0] tap_idx_t;

	// bus side words
	typedef logic [`AXI_ADDR_WIDTH-`AXI_ADDR_LSB-1:0] reg_addr_t;
	typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;

	// one coefficient store from the register file
	typedef struct packed {
		logic en;
		tap_idx_t addr;
		coef_t data;
	} coef_wr_t;

	// tap fetch, shared by both memories
	typedef struct packed {
		logic en;
		tap_idx_t idx;
	} tap_rd_t;

	typedef enum logic [1:0] {MAC_IDLE, MAC_RUN, MAC_DONE} mac_state_e;

endpackage

// ==== source/axi_lite_regs.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module axi_lite_regs
	import fir_pkg::*;
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [`AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input logic [2:0] S_AXI_AWPROT,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input axi_data_t S_AXI_WDATA,
	input logic [`AXI_DATA_WIDTH/8-1:0] S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input logic [`AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
	input logic [2:0] S_AXI_ARPROT,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output axi_data_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	output coef_wr_t coef_wr,
	output logic fir_en,
	output logic [7:0] leds
);

	reg_addr_t axi_awaddr;
	reg_addr_t axi_araddr;
	reg_addr_t coef_off;
	axi_data_t switches;
	axi_data_t reg_data_out;
	logic aw_en;
	logic aw_accept;
	logic reg_wren;
	logic reg_rden;

	// every response is OKAY
	assign S_AXI_BRESP = 2'b00;
	assign S_AXI_RRESP = 2'b00;

	// address and data taken together, one write in flight
	assign aw_accept = !S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && aw_en;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			aw_en <= 1'b1;
		end else if (aw_accept) begin
			S_AXI_AWREADY <= 1'b1;
			S_AXI_WREADY <= 1'b1;
			aw_en <= 1'b0;
		end else begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			// reopen once the response is taken
			if (S_AXI_BREADY && S_AXI_BVALID)
				aw_en <= 1'b1;
		end
	end

	// word address of the pending write
	always_ff @(posedge S_AXI_ACLK) begin
		if (aw_accept)
			axi_awaddr <= S_AXI_AWADDR[`AXI_ADDR_WIDTH-1:`AXI_ADDR_LSB];
	end

	assign reg_wren = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WREADY && S_AXI_WVALID;

	// response raised the cycle after the write, held until BREADY
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_BVALID <= 1'b0;
		else if (reg_wren && !S_AXI_BVALID)
			S_AXI_BVALID <= 1'b1;
		else if (S_AXI_BREADY && S_AXI_BVALID)
			S_AXI_BVALID <= 1'b0;
	end

	// switches, byte lanes follow WSTRB
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches <= '0;
		end else if (reg_wren && axi_awaddr == reg_addr_t'(`REG_SWITCHES)) begin
			for (int b = 0; b < `AXI_DATA_WIDTH / 8; b++) begin
				if (S_AXI_WSTRB[b])
					switches[8*b +: 8] <= S_AXI_WDATA[8*b +: 8];
			end
		end
	end

	// coefficient region decode
	assign coef_off = axi_awaddr - reg_addr_t'(`COEF_BASE);
	assign coef_wr.en = reg_wren && (axi_awaddr >= reg_addr_t'(`COEF_BASE))
		&& (coef_off < reg_addr_t'(`FIR_TAPS));
	assign coef_wr.addr = coef_off[$bits(tap_idx_t)-1:0];
	// sign from bit 31, magnitude bits from the bottom
	assign coef_wr.data = {S_AXI_WDATA[`AXI_DATA_WIDTH-1], S_AXI_WDATA[`FIR_COEF_WIDTH-2:0]};

	assign fir_en = switches[`SWITCH_FIR_EN];
	assign leds = switches[7:0];

	// single cycle address accept, no new read while data is pending
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_ARREADY <= 1'b0;
		else
			S_AXI_ARREADY <= !S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID)
			axi_araddr <= S_AXI_ARADDR[`AXI_ADDR_WIDTH-1:`AXI_ADDR_LSB];
	end

	assign reg_rden = S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_RVALID <= 1'b0;
		else if (reg_rden)
			S_AXI_RVALID <= 1'b1;
		else if (S_AXI_RVALID && S_AXI_RREADY)
			S_AXI_RVALID <= 1'b0;
	end

	// read map, coefficients are write only
	always_comb begin
		case (axi_araddr)
			reg_addr_t'(`REG_NAME): reg_data_out = `PROG_NAME;
			reg_addr_t'(`REG_VER): reg_data_out = `PROG_VER;
			reg_addr_t'(`REG_TAPS): reg_data_out = axi_data_t'(`FIR_TAPS);
			reg_addr_t'(`REG_COEF_MAG): reg_data_out = axi_data_t'(`FIR_COEF_MAG);
			reg_addr_t'(`REG_COEF_BASE): reg_data_out = axi_data_t'(`COEF_BASE);
			reg_addr_t'(`REG_SWITCHES): reg_data_out = switches;
			default: reg_data_out = '0;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (reg_rden)
			S_AXI_RDATA <= reg_data_out;
	end

endmodule

// ==== source/coef_ram.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module coef_ram
	import fir_pkg::*;
(
	input logic S_AXI_ACLK,
	input coef_wr_t coef_wr,
	input tap_rd_t tap_rd,
	output coef_t coef
);

	// one word per tap, all zero from configuration
	coef_t mem [`FIR_TAPS] = '{default: '0};

	// bus side store
	always_ff @(posedge S_AXI_ACLK) begin
		if (coef_wr.en)
			mem[coef_wr.addr] <= coef_wr.data;
	end

	// mac side fetch
	// one cycle latency, lines up with the sample history
	always_ff @(posedge S_AXI_ACLK) begin
		if (tap_rd.en)
			coef <= mem[tap_rd.idx];
	end

endmodule

// ==== source/sample_delay_line.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module sample_delay_line
	import fir_pkg::*;
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic shift_en,
	input sample_t sample_in,
	input tap_rd_t tap_rd,
	output sample_t sample
);

	// index 0 newest
	sample_t hist [`FIR_TAPS];

	// history starts from silence
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int i = 0; i < `FIR_TAPS; i++)
				hist[i] <= '0;
		end else if (shift_en) begin
			hist[0] <= sample_in;
			// oldest sample falls off the end
			for (int i = 1; i < `FIR_TAPS; i++)
				hist[i] <= hist[i-1];
		end
	end

	// tap k gives x[n-k]
	always_ff @(posedge S_AXI_ACLK) begin
		if (tap_rd.en)
			sample <= hist[tap_rd.idx];
	end

endmodule

// ==== source/fir_mac.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module fir_mac
	import fir_pkg::*;
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic fir_en,
	input sample_t flt_in,
	input logic flt_valid,
	input coef_t coef,
	input sample_t sample,
	output logic flt_ready,
	output logic shift_en,
	output tap_rd_t tap_rd,
	output sample_t flt_out,
	output logic out_valid
);

	mac_state_e state;
	tap_idx_t tap_idx;
	acc_t acc;
	logic rd_vld;
	logic accept;
	logic acc_done;

	// busy from the accept through the filtered result
	assign flt_ready = (state == MAC_IDLE) && !(fir_en && out_valid);
	assign accept = flt_valid && flt_ready;
	// history moves on every accept, bypass included
	assign shift_en = accept;

	assign tap_rd.en = (state == MAC_RUN);
	assign tap_rd.idx = tap_idx;

	// last tap summed once the fetch flag has drained
	assign acc_done = (state == MAC_DONE) && !rd_vld;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state <= MAC_IDLE;
			tap_idx <= '0;
			rd_vld <= 1'b0;
		end else begin
			// memories answer one cycle after the fetch
			rd_vld <= tap_rd.en;
			case (state)
				MAC_IDLE: begin
					if (accept && fir_en) begin
						state <= MAC_RUN;
						tap_idx <= '0;
					end
				end
				MAC_RUN: begin
					tap_idx <= tap_idx + 1'b1;
					if (tap_idx == tap_idx_t'(`FIR_TAPS - 1))
						state <= MAC_DONE;
				end
				MAC_DONE: begin
					if (!rd_vld)
						state <= MAC_IDLE;
				end
				default: state <= MAC_IDLE;
			endcase
		end
	end

	// signed mac, fresh sum per accepted sample
	always_ff @(posedge S_AXI_ACLK) begin
		if (accept)
			acc <= '0;
		else if (rd_vld)
			acc <= $signed(acc) + $signed(coef) * $signed(sample);
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			out_valid <= 1'b0;
		else
			out_valid <= (accept && !fir_en) || acc_done;
	end

	// drop the fraction bits, wrap on overflow
	always_ff @(posedge S_AXI_ACLK) begin
		if (accept && !fir_en)
			flt_out <= flt_in;
		else if (acc_done)
			flt_out <= acc[`FIR_COEF_MAG +: `FIR_DATA_WIDTH];
	end

endmodule

// ==== source/fir_top.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module fir_top
	import fir_pkg::*;
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [`AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input logic [2:0] S_AXI_AWPROT,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input axi_data_t S_AXI_WDATA,
	input logic [`AXI_DATA_WIDTH/8-1:0] S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input logic [`AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
	input logic [2:0] S_AXI_ARPROT,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output axi_data_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	input sample_t flt_in,
	input logic flt_valid,
	output logic flt_ready,
	output sample_t flt_out,
	output logic out_valid,
	output logic [7:0] leds
);

	// register file to datapath
	coef_wr_t coef_wr;
	logic fir_en;
	// mac to the two memories
	tap_rd_t tap_rd;
	logic shift_en;
	coef_t coef;
	sample_t sample;

	axi_lite_regs u_regs (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(S_AXI_AWADDR), .S_AXI_AWPROT(S_AXI_AWPROT),
		.S_AXI_AWVALID(S_AXI_AWVALID), .S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_WDATA(S_AXI_WDATA), .S_AXI_WSTRB(S_AXI_WSTRB),
		.S_AXI_WVALID(S_AXI_WVALID), .S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BRESP(S_AXI_BRESP), .S_AXI_BVALID(S_AXI_BVALID), .S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARADDR(S_AXI_ARADDR), .S_AXI_ARPROT(S_AXI_ARPROT),
		.S_AXI_ARVALID(S_AXI_ARVALID), .S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_RDATA(S_AXI_RDATA), .S_AXI_RRESP(S_AXI_RRESP),
		.S_AXI_RVALID(S_AXI_RVALID), .S_AXI_RREADY(S_AXI_RREADY),
		.coef_wr(coef_wr), .fir_en(fir_en), .leds(leds)
	);

	coef_ram u_coef_ram (
		.S_AXI_ACLK(S_AXI_ACLK), .coef_wr(coef_wr), .tap_rd(tap_rd), .coef(coef)
	);

	sample_delay_line u_delay (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN), .shift_en(shift_en),
		.sample_in(flt_in), .tap_rd(tap_rd), .sample(sample)
	);

	fir_mac u_mac (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN), .fir_en(fir_en),
		.flt_in(flt_in), .flt_valid(flt_valid), .coef(coef), .sample(sample),
		.flt_ready(flt_ready), .shift_en(shift_en), .tap_rd(tap_rd),
		.flt_out(flt_out), .out_valid(out_valid)
	);

endmodule

// ==== verif/fir_asserts.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module fir_asserts (
	input logic clk,
	input logic rstn,
	input logic awvalid,
	input logic wvalid,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic fir_en,
	input logic flt_ready,
	input logic out_valid
);

	// response stays up until taken
	assert property (@(posedge clk) disable iff (!rstn) bvalid && !bready |=> bvalid)
		else $error("BVALID dropped before BREADY");

	// busy from the first tap fetch through the filtered result
	assert property (@(posedge clk) disable iff (!rstn)
		out_valid && fir_en |-> !flt_ready && !$past(flt_ready)
			&& !$past(flt_ready, `FIR_TAPS + 2))
		else $error("flt_ready high while the filter was busy");

	// address and data channels hand over in the same cycle
	assert property (@(posedge clk) disable iff (!rstn)
		awready || wready |-> awready && wready && awvalid && wvalid)
		else $error("AWREADY and WREADY out of step with the write valids");

endmodule

bind fir_top fir_asserts u_asserts (
	.clk(S_AXI_ACLK), .rstn(S_AXI_ARESETN), .awvalid(S_AXI_AWVALID),
	.wvalid(S_AXI_WVALID), .awready(S_AXI_AWREADY),
	.wready(S_AXI_WREADY), .bvalid(S_AXI_BVALID), .bready(S_AXI_BREADY),
	.fir_en(fir_en), .flt_ready(flt_ready), .out_valid(out_valid)
);

// ==== verif/fir_tb.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module fir_tb
	import fir_pkg::*;
();

	logic clk;
	logic rstn;
	logic [`AXI_ADDR_WIDTH-1:0] awaddr;
	logic [`AXI_ADDR_WIDTH-1:0] araddr;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic awready, wready, bvalid, arready, rvalid;
	logic [1:0] bresp, rresp;
	axi_data_t wdata, rdata;
	logic [3:0] wstrb;
	sample_t flt_in, flt_out;
	logic flt_valid, flt_ready, out_valid;
	logic [7:0] leds;

	int errors = 0;
	int checks = 0;
	int test_errs = 0;
	int tests = 0;
	int n_cmds = 0;
	int unsigned cyc = 0;
	logic [31:0] rng_state = 32'he8845da4;
	// mode the next accepted sample will see
	logic fir_en_model = 1'b0;
	// outstanding samples, oldest first
	sample_t exp_q[$];
	int unsigned acc_q[$];
	int unsigned lat_q[$];
	logic [7:0] cmd_q[$];
	logic [31:0] arg_a[$];
	logic [31:0] arg_b[$];

	fir_top UUT (
		.S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
		.S_AXI_AWADDR(awaddr), .S_AXI_AWPROT(3'b000), .S_AXI_AWVALID(awvalid),
		.S_AXI_AWREADY(awready), .S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb),
		.S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready), .S_AXI_BRESP(bresp),
		.S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready),
		.S_AXI_ARADDR(araddr), .S_AXI_ARPROT(3'b000), .S_AXI_ARVALID(arvalid),
		.S_AXI_ARREADY(arready), .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
		.S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
		.flt_in(flt_in), .flt_valid(flt_valid), .flt_ready(flt_ready),
		.flt_out(flt_out), .out_valid(out_valid), .leds(leds)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// cycle count for latency checks
	always @(posedge clk)
		cyc <= cyc + 1;

	// xorshift32 step, result below n
	function automatic int unsigned rand_below(input int unsigned n);
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state % n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	// no bus traffic while samples are in flight
	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		int unsigned delay;
		delay = rand_below(4);
		wait_drain();
		@(posedge clk);
		awaddr <= addr[`AXI_ADDR_WIDTH-1:0];
		wdata <= data;
		wstrb <= 4'hf;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(negedge clk); while (!awready);
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		// response must wait for a late BREADY
		repeat (delay) begin
			@(negedge clk);
			check_value("S_AXI_BVALID", bvalid, 1);
		end
		@(posedge clk);
		bready <= 1'b1;
		do @(negedge clk); while (!bvalid);
		check_value("S_AXI_BRESP", bresp, 2'b00);
		@(posedge clk);
		bready <= 1'b0;
		if (addr[`AXI_ADDR_WIDTH-1:`AXI_ADDR_LSB] == `REG_SWITCHES) begin
			fir_en_model = data[`SWITCH_FIR_EN];
			@(negedge clk);
			check_value("leds", leds, data[7:0]);
		end
	endtask

	task automatic axi_read(input logic [31:0] addr, input logic [31:0] exp);
		int unsigned delay;
		delay = rand_below(4);
		wait_drain();
		@(posedge clk);
		araddr <= addr[`AXI_ADDR_WIDTH-1:0];
		arvalid <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		repeat (delay) @(posedge clk);
		rready <= 1'b1;
		do @(negedge clk); while (!rvalid);
		check_value("S_AXI_RDATA", rdata, exp);
		check_value("S_AXI_RRESP", rresp, 2'b00);
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// holds valid until accepted, the result is checked by the monitor
	task automatic send_sample(input logic [31:0] s, input logic [31:0] exp);
		int unsigned gap;
		gap = rand_below(4);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		flt_in <= s[`FIR_DATA_WIDTH-1:0];
		flt_valid <= 1'b1;
		do @(negedge clk); while (!flt_ready);
		exp_q.push_back(exp[`FIR_DATA_WIDTH-1:0]);
		acc_q.push_back(cyc);
		lat_q.push_back(fir_en_model ? `FIR_TAPS + 3 : 1);
		@(posedge clk);
		flt_valid <= 1'b0;
	endtask

	// every out_valid must match one accepted sample
	always @(negedge clk) begin
		if (rstn && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("** Error at %0t ns: out_valid with no sample pending", $time);
				errors++;
				test_errs++;
			end else begin
				check_value("flt_out", flt_out, exp_q.pop_front());
				check_value("out_valid latency", cyc - acc_q.pop_front(), lat_q.pop_front());
			end
		end
	end

	task automatic load_patterns();
		int fd;
		int n;
		string line;
		logic [7:0] c;
		logic [31:0] a, b;
		fd = $fopen("verif/fir_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%c %h %h", c, a, b);
				if (n >= 2 && c != "#") begin
					cmd_q.push_back(c);
					arg_a.push_back(a);
					arg_b.push_back(b);
				end
			end
			$fclose(fd);
			n_cmds = cmd_q.size();
		end
	endtask

	// limit scales with the pattern count
	initial begin
		wait (n_cmds != 0);
		#(n_cmds * (`FIR_TAPS + 20) * 40);
		$display("watchdog expired before the patterns were done");
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		rstn = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		flt_in = '0;
		flt_valid = 1'b0;
		load_patterns();
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		for (int i = 0; i < n_cmds; i++) begin
			case (cmd_q[i])
				"W": axi_write(arg_a[i], arg_b[i]);
				"R": axi_read(arg_a[i], arg_b[i]);
				"S": send_sample(arg_a[i], arg_b[i]);
				"T": begin
					wait_drain();
					repeat (2) @(negedge clk);
					$display("test %0d finished, %0d errors", arg_a[i], test_errs);
					tests++;
					test_errs = 0;
				end
				default: begin
					$display("unknown command in the pattern file");
					errors++;
				end
			endcase
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verif/fir_patterns.txt ====
# W byte_addr data | R byte_addr expected | S sample expected_out | T test_number
# all values hex, samples are 14-bit two's complement
R 000 20524946
R 004 31322E33
R 010 00000008
R 030 00000011
R 040 00000040
R 008 00000000
R 100 00000000
T 1
W 050 000000A5
R 050 000000A5
W 050 C3C35A00
R 050 C3C35A00
T 2
S 0123 0123
S 3FFF 3FFF
S 2000 2000
S 0001 0001
T 3
W 100 00010000
W 050 00000002
S 1000 0800
S 2000 3000
S 0005 0002
S 3FFF 3FFF
T 4
W 100 00008000
W 104 80010000
W 108 00004000
W 10C 00002000
W 11C 80018000
S 1000 0201
S 0000 0000
S 0000 01FF
S 0000 3D00
S 1234 0C8D
S 2ABC 3193
T 5
W 100 00000000
W 104 00010000
W 11C 00000000
W 050 00000000
S 0100 0100
W 050 00000002
S 0200 3EFA
S 3F00 3FCB
T 6

// ==== filelist.f ====
+incdir+source
source/fir_pkg.sv
source/axi_lite_regs.sv
source/coef_ram.sv
source/sample_delay_line.sv
source/fir_mac.sv
source/fir_top.sv
verif/fir_asserts.sv
verif/fir_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fir_tb -f filelist.f -o Vfir_tb
./obj_dir/Vfir_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
	exit 1
fi
exit 0
